/* common/avr_pkg.sv */
// Opcode fields, group codes, ALU operations and register constants imported by every AVR core file
`default_nettype none

package avr_pkg;

	// Register index into the 32-entry file
	typedef logic [4:0] reg_sel_t;

	typedef enum logic [3:0] {
		ALU_MOVE,	// pass Rr
		ALU_MOVR,	// pass constant
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_EOR,
		ALU_LSR,
		ALU_ASR,
		ALU_ROR,
		ALU_ADW,	// word add
		ALU_SBW		// word subtract
	} alu_op_t;

	localparam int PC_W        = 16;
	localparam int DATA_ADDR_W = 16;

	// Low register of each pointer pair
	localparam reg_sel_t BASE_X       = 5'd26;
	localparam reg_sel_t BASE_Y       = 5'd28;
	localparam reg_sel_t BASE_Z       = 5'd30;
	// Immediate forms only reach R16..R31
	localparam reg_sel_t REG_IMM_BASE = 5'd16;

	// Register-register groups matched on opcode[15:10]
	localparam logic [5:0] OP_GRP_CPC = 6'b0000_01;
	localparam logic [5:0] OP_GRP_SBC = 6'b0000_10;
	localparam logic [5:0] OP_GRP_ADD = 6'b0000_11;
	localparam logic [5:0] OP_GRP_CP  = 6'b0001_01;
	localparam logic [5:0] OP_GRP_SUB = 6'b0001_10;
	localparam logic [5:0] OP_GRP_ADC = 6'b0001_11;
	localparam logic [5:0] OP_GRP_AND = 6'b0010_00;
	localparam logic [5:0] OP_GRP_EOR = 6'b0010_01;
	localparam logic [5:0] OP_GRP_OR  = 6'b0010_10;
	localparam logic [5:0] OP_GRP_MOV = 6'b0010_11;

	// Immediate groups matched on opcode[15:12]
	localparam logic [3:0] OP_GRP_CPI  = 4'b0011;
	localparam logic [3:0] OP_GRP_SBCI = 4'b0100;
	localparam logic [3:0] OP_GRP_SUBI = 4'b0101;
	localparam logic [3:0] OP_GRP_ORI  = 4'b0110;
	localparam logic [3:0] OP_GRP_ANDI = 4'b0111;
	localparam logic [3:0] OP_GRP_LDI  = 4'b1110;

	// One-operand group on opcode[15:9] with the function in the low nibble
	localparam logic [6:0] OP_GRP_ONE_OP = 7'b1001_010;
	localparam logic [3:0] OP_LO_COM     = 4'h0;
	localparam logic [3:0] OP_LO_INC     = 4'h3;
	localparam logic [3:0] OP_LO_ASR     = 4'h5;
	localparam logic [3:0] OP_LO_LSR     = 4'h6;
	localparam logic [3:0] OP_LO_ROR     = 4'h7;
	localparam logic [3:0] OP_LO_DEC     = 4'ha;

	// MOVW on opcode[15:8]
	localparam logic [7:0] OP_GRP_MOVW = 8'b0000_0001;

	// LDS/STS and pointer modes share opcode[15:10]
	localparam logic [5:0] OP_GRP_LDS_STS = 6'b1001_00;
	localparam logic [3:0] OP_LO_LDS_STS  = 4'h0;
	localparam logic [5:0] OP_GRP_PTR_X   = 6'b1001_00;
	localparam logic [3:0] OP_LO_PTR_X    = 4'hc;
	// LDD/STD through Y+q or Z+q mask off opcode[13] since it belongs to q
	localparam logic [3:0] OP_GRP_DISP    = 4'b1000;
	localparam logic [3:0] OP_MASK_DISP   = 4'b1101;

	// Status byte bit positions
	localparam logic [2:0] FLAG_C = 3'd0;
	localparam logic [2:0] FLAG_Z = 3'd1;
	localparam logic [2:0] FLAG_N = 3'd2;
	localparam logic [2:0] FLAG_V = 3'd3;
	localparam logic [2:0] FLAG_S = 3'd4;
	localparam logic [2:0] FLAG_H = 3'd5;

endpackage

`default_nettype wire

/* src/avr_alu.sv */
// Combinational byte and word ALU of the core, with AVR status flag rules
`default_nettype none

module avr_alu (
	input  avr_pkg::alu_op_t op,
	input  logic             use_carry,
	input  logic [15:0]      rd_in,
	input  logic [7:0]       rr_in,
	input  logic [7:0]       sreg_in,
	output logic [15:0]      result,
	output logic [7:0]       sreg_out
);
	import avr_pkg::*;

	logic [7:0] a;
	logic [7:0] r;
	logic [8:0] sum8;
	logic [16:0] sum16;
	logic cin;
	logic c;
	logic z;
	logic n;
	logic v;
	logic h;

	always_comb begin
		a = rd_in[7:0];
		cin = use_carry & sreg_in[FLAG_C];
		sum8 = 9'd0;
		sum16 = 17'd0;
		r = rr_in;
		c = sreg_in[FLAG_C];
		h = sreg_in[FLAG_H];
		v = 1'b0;
		// Moves keep the upper byte so MOVW passes a whole pair
		result = {rd_in[15:8], rr_in};

		case (op)
			ALU_ADD: begin
				sum8 = {1'b0, a} + {1'b0, rr_in} + 9'(cin);
				r = sum8[7:0];
				c = sum8[8];
				h = (a[3] & rr_in[3]) | (rr_in[3] & ~r[3]) | (~r[3] & a[3]);
				v = (a[7] & rr_in[7] & ~r[7]) | (~a[7] & ~rr_in[7] & r[7]);
			end
			ALU_SUB: begin
				sum8 = {1'b0, a} - {1'b0, rr_in} - 9'(cin);
				r = sum8[7:0];
				c = sum8[8];
				h = (~a[3] & rr_in[3]) | (rr_in[3] & r[3]) | (r[3] & ~a[3]);
				v = (a[7] & ~rr_in[7] & ~r[7]) | (~a[7] & rr_in[7] & r[7]);
			end
			ALU_AND: r = a & rr_in;
			ALU_OR: r = a | rr_in;
			ALU_EOR: r = a ^ rr_in;
			ALU_LSR: begin
				r = {1'b0, a[7:1]};
				c = a[0];
			end
			ALU_ASR: begin
				r = {a[7], a[7:1]};
				c = a[0];
			end
			ALU_ROR: begin
				r = {cin, a[7:1]};
				c = a[0];
			end
			ALU_ADW: sum16 = {1'b0, rd_in} + {9'd0, rr_in};
			ALU_SBW: sum16 = {1'b0, rd_in} - {9'd0, rr_in};
			default: ;
		endcase

		n = r[7];
		z = (r == 8'h00);
		if (op == ALU_ADW || op == ALU_SBW) begin
			result = sum16[15:0];
			c = sum16[16];
			n = sum16[15];
			z = (sum16[15:0] == 16'h0000);
			v = (op == ALU_ADW) ? (~rd_in[15] & sum16[15]) : (rd_in[15] & ~sum16[15]);
		end else if (op != ALU_MOVE && op != ALU_MOVR) begin
			result = {8'h00, r};
		end

		// SBC, SBCI and CPC only clear Z
		if (op == ALU_SUB && use_carry)
			z = z & sreg_in[FLAG_Z];
		// Shifts set V from N and C
		if (op == ALU_LSR || op == ALU_ASR || op == ALU_ROR)
			v = n ^ c;

		sreg_out = sreg_in;
		sreg_out[FLAG_C] = c;
		sreg_out[FLAG_Z] = z;
		sreg_out[FLAG_N] = n;
		sreg_out[FLAG_V] = v;
		sreg_out[FLAG_S] = n ^ v;
		sreg_out[FLAG_H] = h;
	end

endmodule

`default_nettype wire

/* src/avr_regfile.sv */
// Register file of 32 bytes, registered word and byte reads with write-through, byte or pair write
`default_nettype none

module avr_regfile (
	input  logic              clk,
	input  logic              reset,
	input  avr_pkg::reg_sel_t sel_a,
	input  avr_pkg::reg_sel_t sel_b,
	input  avr_pkg::reg_sel_t wr_sel,
	input  logic [15:0]       wr_data,
	input  logic              wr_en,
	input  logic              wr_word,
	output logic [15:0]       rd_a_word,
	output logic [7:0]        rd_b_byte
);
	import avr_pkg::*;

	logic [7:0] regs [0:31];
	reg_sel_t sel_a_hi;
	reg_sel_t wr_sel_hi;

	// Pairs wrap at R31 like the index arithmetic does
	assign sel_a_hi = sel_a + 5'd1;
	assign wr_sel_hi = wr_sel + 5'd1;

	// Value a register holds after this edge
	function automatic logic [7:0] fwd(input reg_sel_t idx);
		if (wr_en && idx == wr_sel)
			return wr_data[7:0];
		if (wr_en && wr_word && idx == wr_sel_hi)
			return wr_data[15:8];
		return regs[idx];
	endfunction

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_a_word <= 16'h0000;
			rd_b_byte <= 8'h00;
		end else begin
			rd_a_word <= {fwd(sel_a_hi), fwd(sel_a)};
			rd_b_byte <= fwd(sel_b);
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			regs[wr_sel] <= wr_data[7:0];
			// High byte goes to the odd partner
			if (wr_word)
				regs[wr_sel_hi] <= wr_data[15:8];
		end
	end

endmodule

`default_nettype wire

/* src/avr_control.sv */
// First stage of the core: program counter, step counter and opcode decode driving the data port
`default_nettype none

module avr_control (
	input  logic                            clk,
	input  logic                            reset,
	input  logic [15:0]                     cdata,
	input  logic [7:0]                      data_read,
	input  logic [15:0]                     reg_a_word,
	input  logic [7:0]                      reg_b_byte,
	input  logic [15:0]                     alu_result,
	output logic [avr_pkg::PC_W-1:0]        pc,
	output avr_pkg::reg_sel_t               sel_a,
	output avr_pkg::reg_sel_t               sel_b,
	output avr_pkg::reg_sel_t               sel_d,
	output avr_pkg::alu_op_t                alu_op,
	output logic                            alu_store,
	output logic                            alu_word,
	output logic                            alu_carry,
	output logic                            alu_const,
	output logic [7:0]                      const_value,
	output logic [avr_pkg::DATA_ADDR_W-1:0] data_addr,
	output logic                            data_wen,
	output logic                            data_ren,
	output logic [7:0]                      data_write
);
	import avr_pkg::*;

	logic [1:0] step;
	logic [1:0] next_step;
	// Low after reset while the first fetch is still in flight
	logic fetch_valid;
	logic force_pc;
	logic [15:0] prev_opcode;
	logic [15:0] opcode;

	// Opcode fields
	reg_sel_t op_rd;
	reg_sel_t op_rr;
	reg_sel_t op_rdi;
	logic [7:0] op_k;
	logic [5:0] op_q;
	logic is_store;
	logic is_ptr;

	// Extra steps replay the held opcode
	assign opcode = (!fetch_valid || reset) ? 16'h0000 :
		(step == 2'd0) ? cdata : prev_opcode;

	assign op_rd = opcode[8:4];
	assign op_rr = {opcode[9], opcode[3:0]};
	assign op_rdi = REG_IMM_BASE | reg_sel_t'(opcode[7:4]);
	assign op_k = {opcode[11:8], opcode[3:0]};
	assign op_q = {opcode[13], opcode[11:10], opcode[2:0]};
	assign is_store = opcode[9];

	// X+, -X, Y+, -Y, Z+, -Z and plain X
	assign is_ptr = (opcode[15:10] == OP_GRP_LDS_STS && opcode[3:2] != 2'b01 &&
		(opcode[1:0] == 2'b01 || opcode[1:0] == 2'b10)) ||
		(opcode[15:10] == OP_GRP_PTR_X && opcode[3:0] == OP_LO_PTR_X);

	always_ff @(posedge clk) begin
		if (reset) begin
			step <= 2'd0;
			pc <= '0;
			fetch_valid <= 1'b0;
		end else begin
			step <= next_step;
			fetch_valid <= 1'b1;
			// pc leads the decode by one word
			if (force_pc || next_step == 2'd0)
				pc <= pc + 1'b1;
		end
	end

	always_ff @(posedge clk)
		prev_opcode <= opcode;

	always_comb begin
		next_step = 2'd0;
		force_pc = 1'b0;
		data_addr = '0;
		data_wen = 1'b0;
		data_ren = 1'b0;
		data_write = 8'h00;
		alu_op = ALU_MOVE;
		alu_store = 1'b0;
		alu_word = 1'b0;
		alu_carry = 1'b0;
		alu_const = 1'b0;
		const_value = 8'h00;
		sel_a = op_rd;
		sel_b = op_rr;
		sel_d = op_rd;

		// Two-register ALU forms
		case (opcode[15:10])
			OP_GRP_CPC: begin
				alu_op = ALU_SUB;
				alu_carry = 1'b1;
			end
			OP_GRP_CP: alu_op = ALU_SUB;
			OP_GRP_SBC: begin
				alu_op = ALU_SUB;
				alu_carry = 1'b1;
				alu_store = 1'b1;
			end
			OP_GRP_SUB: begin
				alu_op = ALU_SUB;
				alu_store = 1'b1;
			end
			// LSL and ROL are the Rd=Rr cases
			OP_GRP_ADD: begin
				alu_op = ALU_ADD;
				alu_store = 1'b1;
			end
			OP_GRP_ADC: begin
				alu_op = ALU_ADD;
				alu_carry = 1'b1;
				alu_store = 1'b1;
			end
			OP_GRP_AND: begin
				alu_op = ALU_AND;
				alu_store = 1'b1;
			end
			OP_GRP_EOR: begin
				alu_op = ALU_EOR;
				alu_store = 1'b1;
			end
			OP_GRP_OR: begin
				alu_op = ALU_OR;
				alu_store = 1'b1;
			end
			OP_GRP_MOV: alu_store = 1'b1;
			default: ;
		endcase

		// Immediate forms, Rd in R16..R31
		if (opcode[15:12] == OP_GRP_CPI || opcode[15:12] == OP_GRP_SBCI ||
			opcode[15:12] == OP_GRP_SUBI || opcode[15:12] == OP_GRP_ORI ||
			opcode[15:12] == OP_GRP_ANDI || opcode[15:12] == OP_GRP_LDI) begin
			sel_a = op_rdi;
			sel_d = op_rdi;
			alu_const = 1'b1;
			const_value = op_k;
			// CPI only touches flags
			alu_store = (opcode[15:12] != OP_GRP_CPI);
			alu_carry = (opcode[15:12] == OP_GRP_SBCI);
			case (opcode[15:12])
				OP_GRP_ORI: alu_op = ALU_OR;
				OP_GRP_ANDI: alu_op = ALU_AND;
				OP_GRP_LDI: alu_op = ALU_MOVR;
				default: alu_op = ALU_SUB;
			endcase
		end

		// One-operand forms on Rd
		if (opcode[15:9] == OP_GRP_ONE_OP) begin
			case (opcode[3:0])
				OP_LO_COM: begin
					alu_store = 1'b1;
					alu_op = ALU_EOR;
					alu_const = 1'b1;
					const_value = 8'hff;
				end
				OP_LO_INC: begin
					alu_store = 1'b1;
					alu_op = ALU_ADD;
					alu_const = 1'b1;
					const_value = 8'h01;
				end
				OP_LO_DEC: begin
					alu_store = 1'b1;
					alu_op = ALU_SUB;
					alu_const = 1'b1;
					const_value = 8'h01;
				end
				OP_LO_ASR: begin
					alu_store = 1'b1;
					alu_op = ALU_ASR;
				end
				OP_LO_LSR: begin
					alu_store = 1'b1;
					alu_op = ALU_LSR;
				end
				// Carry rotates into bit 7
				OP_LO_ROR: begin
					alu_store = 1'b1;
					alu_op = ALU_ROR;
					alu_carry = 1'b1;
				end
				default: ;
			endcase
		end

		// MOVW, high byte from port a and low byte from port b
		if (opcode[15:8] == OP_GRP_MOVW) begin
			sel_a = {opcode[3:0], 1'b0};
			sel_b = {opcode[3:0], 1'b0};
			sel_d = {opcode[7:4], 1'b0};
			alu_word = 1'b1;
			alu_store = 1'b1;
		end

		if (opcode[15:10] == OP_GRP_LDS_STS && opcode[3:0] == OP_LO_LDS_STS) begin
			case (step)
				// Address word is being fetched, Rd read under way
				2'd0: begin
					force_pc = 1'b1;
					next_step = 2'd1;
				end
				2'd1: begin
					data_addr = cdata;
					if (is_store) begin
						data_wen = 1'b1;
						data_write = reg_a_word[7:0];
					end else begin
						data_ren = 1'b1;
						next_step = 2'd2;
					end
				end
				// LDS only, loaded byte through the ALU into Rd
				default: begin
					alu_op = ALU_MOVR;
					alu_store = 1'b1;
					alu_const = 1'b1;
					const_value = data_read;
				end
			endcase
		end else if (is_ptr) begin
			case (opcode[3:2])
				2'b00: sel_a = BASE_Z;
				2'b10: sel_a = BASE_Y;
				default: sel_a = BASE_X;
			endcase
			sel_b = op_rd;
			sel_d = sel_a;
			case (step)
				// Pointer +/- 1 written back as a word
				2'd0: begin
					next_step = 2'd1;
					alu_word = 1'b1;
					alu_const = 1'b1;
					const_value = 8'h01;
					if (opcode[1:0] == 2'b01) begin
						alu_op = ALU_ADW;
						alu_store = 1'b1;
					end else if (opcode[1:0] == 2'b10) begin
						alu_op = ALU_SBW;
						alu_store = 1'b1;
					end
				end
				2'd1: begin
					// Pre-decrement uses the decremented value
					data_addr = (opcode[1:0] == 2'b10) ? alu_result : reg_a_word;
					if (is_store) begin
						data_wen = 1'b1;
						data_write = reg_b_byte;
					end else begin
						data_ren = 1'b1;
						next_step = 2'd2;
					end
				end
				default: begin
					sel_d = op_rd;
					alu_op = ALU_MOVR;
					alu_store = 1'b1;
					alu_const = 1'b1;
					const_value = data_read;
				end
			endcase
		end else if ((opcode[15:12] & OP_MASK_DISP) == OP_GRP_DISP) begin
			case (step)
				// Y+q or Z+q computed, pointer left unchanged
				2'd0: begin
					sel_a = opcode[3] ? BASE_Y : BASE_Z;
					sel_b = op_rd;
					alu_op = ALU_ADW;
					alu_const = 1'b1;
					const_value = {2'b00, op_q};
					next_step = 2'd1;
				end
				2'd1: begin
					sel_b = op_rd;
					data_addr = alu_result;
					if (is_store) begin
						data_wen = 1'b1;
						data_write = reg_b_byte;
					end else begin
						data_ren = 1'b1;
						next_step = 2'd2;
					end
				end
				default: begin
					alu_op = ALU_MOVR;
					alu_store = 1'b1;
					alu_const = 1'b1;
					const_value = data_read;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/avr_execute.sv */
// Second stage: holds the decoded controls one cycle, picks the operand and keeps the status byte
`default_nettype none

module avr_execute (
	input  logic              clk,
	input  logic              reset,
	input  avr_pkg::alu_op_t  alu_op,
	input  logic              alu_store,
	input  logic              alu_word,
	input  logic              alu_carry,
	input  logic              alu_const,
	input  logic [7:0]        const_value,
	input  avr_pkg::reg_sel_t sel_d,
	input  logic [15:0]       reg_a_word,
	input  logic [7:0]        reg_b_byte,
	output logic [15:0]       alu_result,
	output avr_pkg::reg_sel_t wr_sel,
	output logic              wr_en,
	output logic              wr_word
);
	import avr_pkg::*;

	alu_op_t ex_op;
	logic ex_carry;
	logic ex_const;
	logic [7:0] ex_value;
	logic [7:0] operand_b;
	logic [7:0] sreg;
	logic [7:0] sreg_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			ex_op <= ALU_MOVE;
			wr_en <= 1'b0;
			wr_word <= 1'b0;
			ex_carry <= 1'b0;
			ex_const <= 1'b0;
			sreg <= 8'h00;
		end else begin
			ex_op <= alu_op;
			wr_en <= alu_store;
			wr_word <= alu_word;
			ex_carry <= alu_carry;
			ex_const <= alu_const;
			// Plain moves and loads leave the flags alone
			if (ex_op != ALU_MOVE && ex_op != ALU_MOVR)
				sreg <= sreg_next;
		end
	end

	always_ff @(posedge clk) begin
		ex_value <= const_value;
		wr_sel <= sel_d;
	end

	// Constant replaces Rr
	assign operand_b = ex_const ? ex_value : reg_b_byte;

	avr_alu alu (
		.op(ex_op),
		.use_carry(ex_carry),
		.rd_in(reg_a_word),
		.rr_in(operand_b),
		.sreg_in(sreg),
		.result(alu_result),
		.sreg_out(sreg_next)
	);

endmodule

`default_nettype wire

/* src/avr_cpu.sv */
// Top of the two-stage AVR core; connect pc/cdata to program memory, data_* to data memory
`default_nettype none

module avr_cpu (
	input  logic        clk,
	input  logic        reset,
	output logic [15:0] pc,
	input  logic [15:0] cdata,
	output logic [15:0] data_addr,
	output logic        data_wen,
	output logic        data_ren,
	input  logic [7:0]  data_read,
	output logic [7:0]  data_write
);
	import avr_pkg::*;

	// Decode stage to register file
	reg_sel_t sel_a;
	reg_sel_t sel_b;
	logic [15:0] reg_a_word;
	logic [7:0] reg_b_byte;

	// Decode stage to execute stage
	reg_sel_t sel_d;
	alu_op_t alu_op;
	logic alu_store;
	logic alu_word;
	logic alu_carry;
	logic alu_const;
	logic [7:0] const_value;
	logic [15:0] alu_result;

	// Write-back port
	reg_sel_t wr_sel;
	logic wr_en;
	logic wr_word;

	avr_control control (
		.clk(clk),
		.reset(reset),
		.cdata(cdata),
		.data_read(data_read),
		.reg_a_word(reg_a_word),
		.reg_b_byte(reg_b_byte),
		.alu_result(alu_result),
		.pc(pc),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.sel_d(sel_d),
		.alu_op(alu_op),
		.alu_store(alu_store),
		.alu_word(alu_word),
		.alu_carry(alu_carry),
		.alu_const(alu_const),
		.const_value(const_value),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_write(data_write)
	);

	avr_execute execute (
		.clk(clk),
		.reset(reset),
		.alu_op(alu_op),
		.alu_store(alu_store),
		.alu_word(alu_word),
		.alu_carry(alu_carry),
		.alu_const(alu_const),
		.const_value(const_value),
		.sel_d(sel_d),
		.reg_a_word(reg_a_word),
		.reg_b_byte(reg_b_byte),
		.alu_result(alu_result),
		.wr_sel(wr_sel),
		.wr_en(wr_en),
		.wr_word(wr_word)
	);

	avr_regfile regs (
		.clk(clk),
		.reset(reset),
		.sel_a(sel_a),
		.sel_b(sel_b),
		.wr_sel(wr_sel),
		.wr_data(alu_result),
		.wr_en(wr_en),
		.wr_word(wr_word),
		.rd_a_word(reg_a_word),
		.rd_b_byte(reg_b_byte)
	);

endmodule

`default_nettype wire

/* bench/tb_memories.sv */
// Behavioural program and data memories with one-cycle reads, plus AVR opcode encoders for the testbench
`default_nettype none

// Immediate form, Rd in R16..R31 so only the low four index bits go in
function automatic logic [15:0] imm_code(input logic [3:0] top, input logic [4:0] d,
	input logic [7:0] k);
	return {top, k[7:4], d[3:0], k[3:0]};
endfunction

function automatic logic [15:0] two_reg_code(input logic [5:0] grp, input logic [4:0] d,
	input logic [4:0] r);
	return {grp, r[4], d, r[3:0]};
endfunction

// COM, INC, DEC, ASR, LSR, ROR
function automatic logic [15:0] one_op_code(input logic [3:0] lo, input logic [4:0] d);
	return {7'b1001_010, d, lo};
endfunction

// Pair indices, even registers only
function automatic logic [15:0] movw_code(input logic [4:0] d, input logic [4:0] r);
	return {8'h01, d[4:1], r[4:1]};
endfunction

// LDS or STS first word, address word follows
function automatic logic [15:0] direct_code(input logic store, input logic [4:0] d);
	return {6'b1001_00, store, d, 4'h0};
endfunction

// LD/ST through X, Y or Z with the mode nibble
function automatic logic [15:0] pointer_code(input logic store, input logic [4:0] d,
	input logic [3:0] mode);
	return {6'b1001_00, store, d, mode};
endfunction

// LDD/STD with Y+q or Z+q
function automatic logic [15:0] disp_code(input logic store, input logic [4:0] d,
	input logic use_y, input logic [5:0] q);
	return {2'b10, q[5], 1'b0, q[4:3], store, d, use_y, q[2:0]};
endfunction

module program_memory (
	input  logic        clk,
	input  logic [15:0] addr,
	output logic [15:0] data
);
	logic [15:0] mem [0:255];

	initial
		data = 16'h0000;

	// Word arrives one clock after its address
	always @(posedge clk)
		data <= mem[addr[7:0]];
endmodule

module data_memory (
	input  logic        clk,
	input  logic [15:0] addr,
	input  logic        wen,
	input  logic        ren,
	input  logic [7:0]  wdata,
	output logic [7:0]  rdata
);
	logic [7:0] mem [0:65535];

	initial
		rdata = 8'h00;

	// Write at the edge, read data valid the following cycle
	always @(posedge clk) begin
		if (wen)
			mem[addr] <= wdata;
		if (ren)
			rdata <= mem[addr];
	end
endmodule

`default_nettype wire

/* bench/avr_cpu_sva_sva.sv */
// Assertions on the core's memory ports and reset, bound into every avr_cpu instance
`default_nettype none

module avr_cpu_sva (
	input logic        clk,
	input logic        reset,
	input logic [15:0] pc,
	input logic        data_wen,
	input logic        data_ren
);

	// One data access per cycle at most
	read_write_exclusive: assert property (@(posedge clk) !(data_wen && data_ren))
		else $error("data_wen and data_ren high in the same cycle");

	// Data port idle while held in reset
	idle_in_reset: assert property (@(posedge clk) reset |-> !data_wen && !data_ren)
		else $error("data port active during reset");

	// Fetch restarts from word 0
	pc_cleared: assert property (@(posedge clk) reset |=> pc == 16'h0000)
		else $error("pc not 0 in the cycle after reset");

endmodule

bind avr_cpu avr_cpu_sva port_checks (
	.clk(clk),
	.reset(reset),
	.pc(pc),
	.data_wen(data_wen),
	.data_ren(data_ren)
);

`default_nettype wire

/* bench/tb_avr_cpu.sv */
// Top-level testbench of the AVR core run as the simulation top to drive programs and check writes
`default_nettype none

module tb_avr_cpu;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 3;
	// Cycle limits of each test's write capture
	localparam int LIMIT_LDI = 120;
	localparam int LIMIT_ALU = 150;
	localparam int LIMIT_CARRY = 60;
	localparam int LIMIT_LOAD = 60;
	localparam int LIMIT_PTR = 100;
	localparam int LIMIT_RESET = 40;
	// Seven reset pulses plus slack for the edge waits around them
	localparam int WATCHDOG_CYCLES = LIMIT_LDI + LIMIT_ALU + LIMIT_CARRY + LIMIT_LOAD +
		LIMIT_PTR + 2 * LIMIT_RESET + 7 * (RESET_CYCLES + 3);

	logic clk;
	logic reset;
	logic [15:0] pc;
	logic [15:0] cdata;
	logic [15:0] data_addr;
	logic data_wen;
	logic data_ren;
	logic [7:0] data_read;
	logic [7:0] data_write;

	integer seed;
	int errors;
	// Next free program word
	int wp;
	// Captured data writes in arrival order
	logic [15:0] got_addr [$];
	logic [7:0] got_data [$];
	time got_time [$];

	avr_cpu UUT (
		.clk(clk),
		.reset(reset),
		.pc(pc),
		.cdata(cdata),
		.data_addr(data_addr),
		.data_wen(data_wen),
		.data_ren(data_ren),
		.data_read(data_read),
		.data_write(data_write)
	);

	program_memory pmem (
		.clk(clk),
		.addr(pc),
		.data(cdata)
	);

	data_memory dmem (
		.clk(clk),
		.addr(data_addr),
		.wen(data_wen),
		.ren(data_ren),
		.wdata(data_write),
		.rdata(data_read)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [7:0] random_byte();
		logic [31:0] r;
		r = $random(seed);
		return r[7:0];
	endfunction

	// Preload pattern where every address bit has an effect
	function automatic logic [7:0] fill_byte(input logic [15:0] a);
		return a[7:0] ^ {a[11:8], a[15:12]} ^ 8'h3c;
	endfunction

	// Expected Rd from the instruction set definition
	function automatic logic [7:0] result_of(input int op, input logic [7:0] a,
		input logic [7:0] b, input logic c);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return b;
			6: return ~a;
			7: return a + 8'd1;
			8: return a - 8'd1;
			9: return {1'b0, a[7:1]};
			10: return {a[7], a[7:1]};
			default: return {c, a[7:1]};
		endcase
	endfunction

	// Same order as result_of with Rd=R16 and Rr=R17
	function automatic logic [15:0] alu_opcode(input int op);
		case (op)
			0: return two_reg_code(6'b0000_11, 5'd16, 5'd17);
			1: return two_reg_code(6'b0001_10, 5'd16, 5'd17);
			2: return two_reg_code(6'b0010_00, 5'd16, 5'd17);
			3: return two_reg_code(6'b0010_10, 5'd16, 5'd17);
			4: return two_reg_code(6'b0010_01, 5'd16, 5'd17);
			5: return two_reg_code(6'b0010_11, 5'd16, 5'd17);
			6: return one_op_code(4'h0, 5'd16);
			7: return one_op_code(4'h3, 5'd16);
			8: return one_op_code(4'ha, 5'd16);
			9: return one_op_code(4'h6, 5'd16);
			10: return one_op_code(4'h5, 5'd16);
			default: return one_op_code(4'h7, 5'd16);
		endcase
	endfunction

	// Core held in reset while the program is rewritten
	task automatic start_load();
		@(posedge clk);
		reset <= 1'b1;
		for (int i = 0; i < 256; i++)
			pmem.mem[i] = 16'h0000;
		wp = 0;
	endtask

	task automatic emit(input logic [15:0] w);
		pmem.mem[wp] = w;
		wp++;
	endtask

	task automatic load_imm(input logic [4:0] d, input logic [7:0] k);
		emit(imm_code(4'he, d, k));
	endtask

	task automatic store(input logic [15:0] addr, input logic [4:0] r);
		emit(direct_code(1'b1, r));
		emit(addr);
	endtask

	task automatic release_reset();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
	endtask

	// Capture writes mid-cycle until n arrive or the limit runs out
	task automatic collect(input int n, input int limit);
		int cycles;
		cycles = 0;
		got_addr.delete();
		got_data.delete();
		got_time.delete();
		while (got_addr.size() < n && cycles < limit) begin
			@(negedge clk);
			if (data_wen) begin
				got_addr.push_back(data_addr);
				got_data.push_back(data_write);
				got_time.push_back($time);
			end
			cycles++;
		end
		if (got_addr.size() < n) begin
			errors++;
			$display("Only %0d of %0d data writes seen within %0d cycles at time %0t",
				got_addr.size(), n, limit, $time);
		end
	endtask

	task automatic check_write(input int idx, input logic [15:0] addr, input logic [7:0] data);
		if (idx >= got_addr.size()) begin
			errors++;
			$display("Write %0d to address %h never happened", idx, addr);
		end else begin
			if (got_addr[idx] !== addr) begin
				errors++;
				$display("CHECK FAILED at %0t: data_addr of write %0d is %h, expected %h",
					got_time[idx], idx, got_addr[idx], addr);
			end
			if (got_data[idx] !== data) begin
				errors++;
				$display("CHECK FAILED at %0t: data_write of write %0d is %h, expected %h",
					got_time[idx], idx, got_data[idx], data);
			end
		end
	endtask

	// R16..R31 each stored to its own address
	task automatic ldi_then_sts();
		logic [7:0] k [16];
		start_load();
		for (int i = 0; i < 16; i++) begin
			k[i] = random_byte();
			load_imm(5'(16 + i), k[i]);
			store(16'h0100 + 16'(i), 5'(16 + i));
		end
		release_reset();
		collect(16, LIMIT_LDI);
		for (int i = 0; i < 16; i++)
			check_write(i, 16'h0100 + 16'(i), k[i]);
	endtask

	task automatic register_alu();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] expect_byte [12];
		logic c;
		c = 1'b0;
		start_load();
		for (int i = 0; i < 12; i++) begin
			a = random_byte();
			b = random_byte();
			// Negative odd ASR operand so the sign copy and the carry into ROR both show
			if (i == 10)
				a = a | 8'h81;
			load_imm(5'd16, a);
			load_imm(5'd17, b);
			emit(alu_opcode(i));
			store(16'h0200 + 16'(i), 5'd16);
			expect_byte[i] = result_of(i, a, b, c);
			// LSR and ASR leave bit 0 in C for the ROR right after
			if (i == 9 || i == 10)
				c = a[0];
		end
		release_reset();
		collect(12, LIMIT_ALU);
		for (int i = 0; i < 12; i++)
			check_write(i, 16'h0200 + 16'(i), expect_byte[i]);
	endtask

	task automatic carry_chain();
		logic [15:0] x;
		logic [15:0] y;
		logic [15:0] p;
		logic [15:0] k;
		logic [15:0] sum;
		logic [15:0] diff;
		// Low bytes forced so that carry and borrow really cross
		x = {random_byte(), random_byte() | 8'h80};
		y = {random_byte(), random_byte() | 8'h80};
		p = {random_byte(), random_byte() & 8'h7f};
		k = {random_byte(), random_byte() | 8'h80};
		sum = x + y;
		diff = p - k;
		start_load();
		load_imm(5'd16, x[7:0]);
		load_imm(5'd17, x[15:8]);
		load_imm(5'd18, y[7:0]);
		load_imm(5'd19, y[15:8]);
		emit(two_reg_code(6'b0000_11, 5'd16, 5'd18));
		emit(two_reg_code(6'b0001_11, 5'd17, 5'd19));
		store(16'h0300, 5'd16);
		store(16'h0301, 5'd17);
		load_imm(5'd20, p[7:0]);
		load_imm(5'd21, p[15:8]);
		emit(imm_code(4'h5, 5'd20, k[7:0]));
		emit(imm_code(4'h4, 5'd21, k[15:8]));
		store(16'h0302, 5'd20);
		store(16'h0303, 5'd21);
		release_reset();
		collect(4, LIMIT_CARRY);
		check_write(0, 16'h0300, sum[7:0]);
		check_write(1, 16'h0301, sum[15:8]);
		check_write(2, 16'h0302, diff[7:0]);
		check_write(3, 16'h0303, diff[15:8]);
	endtask

	task automatic load_path();
		logic [15:0] src;
		logic [7:0] lo;
		logic [7:0] hi;
		src = 16'h0400 | 16'(random_byte());
		lo = random_byte();
		hi = random_byte();
		start_load();
		emit(direct_code(1'b0, 5'd20));
		emit(src);
		emit(one_op_code(4'h3, 5'd20));
		store(16'h0500, 5'd20);
		load_imm(5'd22, lo);
		load_imm(5'd23, hi);
		// R25:R24 <= R23:R22
		emit(movw_code(5'd24, 5'd22));
		store(16'h0501, 5'd24);
		store(16'h0502, 5'd25);
		release_reset();
		collect(3, LIMIT_LOAD);
		check_write(0, 16'h0500, fill_byte(src) + 8'd1);
		check_write(1, 16'h0501, lo);
		check_write(2, 16'h0502, hi);
	endtask

	task automatic pointer_modes();
		logic [15:0] xp;
		logic [15:0] yp;
		logic [15:0] zp;
		logic [5:0] q;
		logic [7:0] v [3];
		logic [15:0] final_ptr [3];
		xp = {8'h06, random_byte()};
		yp = {8'h07, random_byte()};
		zp = {8'h08, random_byte()};
		q = 6'(random_byte());
		for (int i = 0; i < 3; i++)
			v[i] = random_byte();
		start_load();
		load_imm(5'd26, xp[7:0]);
		load_imm(5'd27, xp[15:8]);
		load_imm(5'd28, yp[7:0]);
		load_imm(5'd29, yp[15:8]);
		load_imm(5'd30, zp[7:0]);
		load_imm(5'd31, zp[15:8]);
		// ST X+, ST -Y, STD Z+q
		load_imm(5'd16, v[0]);
		emit(pointer_code(1'b1, 5'd16, 4'hd));
		load_imm(5'd17, v[1]);
		emit(pointer_code(1'b1, 5'd17, 4'ha));
		load_imm(5'd18, v[2]);
		emit(disp_code(1'b1, 5'd18, 1'b0, q));
		// LD Y+ reads back the byte the -Y store left
		emit(pointer_code(1'b0, 5'd19, 4'h9));
		store(16'h0900, 5'd19);
		for (int i = 0; i < 6; i++)
			store(16'h0901 + 16'(i), 5'(26 + i));
		release_reset();
		collect(10, LIMIT_PTR);
		check_write(0, xp, v[0]);
		check_write(1, yp - 16'd1, v[1]);
		check_write(2, zp + 16'(q), v[2]);
		check_write(3, 16'h0900, v[1]);
		// X ends one up while Y and Z end where they started
		final_ptr[0] = xp + 16'd1;
		final_ptr[1] = yp;
		final_ptr[2] = zp;
		for (int j = 0; j < 3; j++) begin
			check_write(4 + 2 * j, 16'h0901 + 16'(2 * j), final_ptr[j][7:0]);
			check_write(5 + 2 * j, 16'h0902 + 16'(2 * j), final_ptr[j][15:8]);
		end
	endtask

	task automatic reset_restart();
		logic [7:0] k;
		logic [7:0] k2;
		k = random_byte();
		k2 = random_byte();
		start_load();
		load_imm(5'd16, k);
		store(16'h0a00, 5'd16);
		// Second store would write while the reset pulse is held
		load_imm(5'd17, k2);
		store(16'h0a01, 5'd17);
		release_reset();
		collect(1, LIMIT_RESET);
		check_write(0, 16'h0a00, k);
		@(posedge clk);
		reset <= 1'b1;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			if (data_wen !== 1'b0) begin
				errors++;
				$display("CHECK FAILED at %0t: data_wen is %b during reset, expected 0",
					$time, data_wen);
			end
		end
		@(posedge clk);
		reset <= 1'b0;
		// Program restarts at word 0
		collect(1, LIMIT_RESET);
		check_write(0, 16'h0a00, k);
	endtask

	initial begin
		seed = 32'h97da_1eac;
		errors = 0;
		wp = 0;
		clk = 1'b0;
		reset = 1'b1;
		for (int a = 0; a < 65536; a++)
			dmem.mem[a] = fill_byte(16'(a));
		ldi_then_sts();
		register_alu();
		carry_chain();
		load_path();
		pointer_modes();
		reset_restart();
		$display("Error count: %0d", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Stops a run that outlives every test limit
	initial begin
		#(CLK_PERIOD * WATCHDOG_CYCLES);
		$display("Watchdog expired after %0d cycles before the tests completed",
			WATCHDOG_CYCLES);
		$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
common/avr_pkg.sv
src/avr_alu.sv
src/avr_regfile.sv
src/avr_control.sv
src/avr_execute.sv
src/avr_cpu.sv
bench/tb_memories.sv
bench/avr_cpu_sva_sva.sv
bench/tb_avr_cpu.sv
